// File: cache/cache_lookup.sv
// **************************************
// request stage of the cache. holds the request being
// looked up and decides when the pipeline may move.
// **************************************

`timescale 1ns/1ps

module cache_lookup import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  // client request.
  input  logic        req_valid,
  input  cache_addr_t req_addr,
  output logic        req_ready,
  // response side and lookup result.
  input  logic        rsp_ready,
  input  logic        hit,
  // to the ways and the selector.
  output logic        advance,
  output logic        pending,
  output cache_addr_t addr_buf
);

  // move on when the client takes the answer and the
  // buffered request is either done or empty.
  assign advance   = rsp_ready && (hit || !pending);
  assign req_ready = advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (advance) begin
      pending <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      addr_buf <= req_addr;
    end
  end

  // **************************************
  // checks
  // **************************************

  // a missing request must keep its address until the refill
  // has brought the word in, since the refill reads it.
  a_hold_on_miss: assert property (
    @(posedge clk) disable iff (rst)
    (pending && !hit) |=> $stable(addr_buf)
  ) else $error("lookup address changed during a miss.");

endmodule

// File: cache/cache_select.sv
// **************************************
// merges the ways into one answer, picks the byte and
// keeps the round-robin victim pointer of every set.
// **************************************

`timescale 1ns/1ps

module cache_select import cache_pkg::*; #(
  parameter int N_WAYS = 2
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          advance,
  input  offset_t                       offset,
  input  index_t                        index_buf,
  input  logic                          pending,
  input  logic [N_WAYS-1:0]             way_hit,
  input  logic [N_WAYS*WORD_BITS-1:0]   way_data,
  input  logic                          fill_en,
  output logic                          hit,
  output logic                          miss,
  output logic [way_bits(N_WAYS)-1:0]   victim,
  output logic                          rsp_valid,
  output logic [BYTE_BITS-1:0]          rsp_data
);

  localparam int WAY_BITS = way_bits(N_WAYS);

  offset_t              offset_q;
  logic [WORD_BITS-1:0] hit_word;
  logic [1:0]           byte_idx;
  logic [WAY_BITS-1:0]  rr [N_SETS];

  always_ff @(posedge clk) begin
    if (advance) begin
      offset_q <= offset;
    end
  end

  // at most one way hits, so an or of the masked words is a mux.
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < N_WAYS; w++) begin
      if (way_hit[w]) hit_word = hit_word | way_data[w*WORD_BITS +: WORD_BITS];
    end
  end

  assign hit       = |way_hit;
  assign miss      = pending && !hit;
  assign rsp_valid = pending && hit;

  assign byte_idx = ~offset_q;  // offset 0 is the top byte.
  assign rsp_data = hit_word[{byte_idx, 3'b000} +: BYTE_BITS];

  // **************************************
  // round-robin victim per set
  // **************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < N_SETS; s++) rr[s] <= '0;
    end else if (fill_en) begin
      // the missing request still sits in the lookup buffer.
      rr[index_buf] <= (rr[index_buf] == WAY_BITS'(N_WAYS - 1)) ? '0
                                                                 : rr[index_buf] + 1'b1;
    end
  end

  assign victim = rr[index_buf];

  a_one_hit: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(way_hit)
  ) else $error("more than one way hit.");

endmodule

// File: cache/cache_way.sv
// **************************************
// one way of the cache: valid, tag and data per set,
// a registered read port and the refill write port.
// **************************************

`timescale 1ns/1ps

module cache_way import cache_pkg::*; #(
  parameter int N_WAYS = 2,
  parameter int WAY_ID = 0
) (
  input  logic                         clk,
  input  logic                         rst,
  // lookup side.
  input  logic                         advance,
  input  index_t                       rd_index,
  input  tag_t                         cmp_tag,
  // refill side.
  input  logic                         fill_en,
  input  logic [way_bits(N_WAYS)-1:0]  fill_way,
  input  index_t                       fill_index,
  input  tag_t                         fill_tag,
  input  logic [WORD_BITS-1:0]         fill_data,
  // result.
  output logic                         way_hit,
  output logic [WORD_BITS-1:0]         way_data
);

  localparam int WAY_BITS = way_bits(N_WAYS);

  logic [N_SETS-1:0]    valid;
  tag_t                 tag_mem [N_SETS];
  logic [WORD_BITS-1:0] data_mem [N_SETS];

  logic                 valid_q;
  tag_t                 tag_q;
  logic [WORD_BITS-1:0] data_q;

  logic fill_sel;

  assign fill_sel = fill_en && (fill_way == WAY_BITS'(WAY_ID));

  // **************************************
  // valid bits
  // **************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      valid   <= '0;
      valid_q <= 1'b0;
    end else if (fill_sel) begin
      valid[fill_index] <= 1'b1;
      valid_q           <= 1'b1;   // refilled entry is read back at once.
    end else if (advance) begin
      valid_q <= valid[rd_index];
    end
  end

  // **************************************
  // tag and data arrays
  // **************************************

  always_ff @(posedge clk) begin
    if (fill_sel) begin
      tag_mem[fill_index]  <= fill_tag;
      data_mem[fill_index] <= fill_data;
      tag_q                <= fill_tag;
      data_q               <= fill_data;
    end else if (advance) begin
      tag_q  <= tag_mem[rd_index];
      data_q <= data_mem[rd_index];
    end
  end

  // cmp_tag comes from the buffered address, in step with the read.
  assign way_hit  = valid_q && (tag_q == cmp_tag);
  assign way_data = data_q;

endmodule

// File: common/cache_pkg.sv
// **************************************
// shared widths and address layout of the byte cache.
// imported by every cache module and by the testbench.
// **************************************

package cache_pkg;

  // address split, big-endian bytes inside a word.
  localparam int TAG_BITS    = 9;
  localparam int INDEX_BITS  = 5;
  localparam int OFFSET_BITS = 2;

  localparam int ADDR_BITS      = TAG_BITS + INDEX_BITS + OFFSET_BITS;
  localparam int WORD_ADDR_BITS = ADDR_BITS - OFFSET_BITS;
  localparam int N_SETS         = 1 << INDEX_BITS;

  localparam int WORD_BITS = 32;
  localparam int BYTE_BITS = 8;

  typedef logic [TAG_BITS-1:0]       tag_t;
  typedef logic [INDEX_BITS-1:0]     index_t;
  typedef logic [OFFSET_BITS-1:0]    offset_t;
  typedef logic [WORD_ADDR_BITS-1:0] word_t;

  // one request address, seen by the lookup as tag/index/offset
  // and by the memory side as word address plus byte select.
  typedef union packed {
    struct packed {
      tag_t    tag;
      index_t  index;
      offset_t offset;
    } fields;
    struct packed {
      word_t   word;
      offset_t byte_sel;
    } mem;
  } cache_addr_t;

  // width of a way number, never below one bit.
  function automatic int way_bits(input int n_ways);
    return (n_ways > 1) ? $clog2(n_ways) : 1;
  endfunction

endpackage

// File: list.f
common/cache_pkg.sv
cache/cache_lookup.sv
cache/cache_way.sv
cache/cache_select.sv
source/refill_master.sv
source/cache_top.sv
tb/wb_mem_model.sv
tb/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the cache testbench with verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/cache_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" <<< "$output"; then
  exit 0
fi
exit 1

// File: source/cache_top.sv
// **************************************
// read-only set-associative byte cache. client handshake
// in front, wishbone classic read master behind.
// **************************************

`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
  parameter int N_WAYS = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  // client request.
  input  logic                 req_valid,
  input  cache_addr_t          req_addr,
  output logic                 req_ready,
  // client response.
  output logic                 rsp_valid,
  output logic [BYTE_BITS-1:0] rsp_data,
  input  logic                 rsp_ready,
  // wishbone master.
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output word_t                wb_adr,
  input  logic [WORD_BITS-1:0] wb_dat_r,
  input  logic                 wb_ack
);

  localparam int WAY_BITS = way_bits(N_WAYS);

  logic                        advance;
  logic                        pending;
  cache_addr_t                 addr_buf;
  logic                        hit;
  logic                        miss;
  logic [WAY_BITS-1:0]         victim;
  logic [N_WAYS-1:0]           way_hit;
  logic [N_WAYS*WORD_BITS-1:0] way_data;
  logic                        fill_en;
  logic [WAY_BITS-1:0]         fill_way;
  index_t                      fill_index;
  tag_t                        fill_tag;
  logic [WORD_BITS-1:0]        fill_data;

  cache_lookup u_lookup (
    .clk(clk), .rst(rst),
    .req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
    .rsp_ready(rsp_ready), .hit(hit),
    .advance(advance), .pending(pending), .addr_buf(addr_buf)
  );

  // ways read the incoming index and compare against the buffered tag.
  for (genvar w = 0; w < N_WAYS; w++) begin : g_way
    cache_way #(.N_WAYS(N_WAYS), .WAY_ID(w)) u_way (
      .clk(clk), .rst(rst),
      .advance(advance), .rd_index(req_addr.fields.index), .cmp_tag(addr_buf.fields.tag),
      .fill_en(fill_en), .fill_way(fill_way), .fill_index(fill_index),
      .fill_tag(fill_tag), .fill_data(fill_data),
      .way_hit(way_hit[w]), .way_data(way_data[w*WORD_BITS +: WORD_BITS])
    );
  end

  cache_select #(.N_WAYS(N_WAYS)) u_select (
    .clk(clk), .rst(rst),
    .advance(advance), .offset(req_addr.fields.offset), .index_buf(addr_buf.fields.index),
    .pending(pending), .way_hit(way_hit), .way_data(way_data), .fill_en(fill_en),
    .hit(hit), .miss(miss), .victim(victim),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data)
  );

  refill_master #(.N_WAYS(N_WAYS)) u_refill (
    .clk(clk), .rst(rst),
    .miss(miss), .addr_buf(addr_buf), .victim(victim),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .fill_en(fill_en), .fill_way(fill_way), .fill_index(fill_index),
    .fill_tag(fill_tag), .fill_data(fill_data)
  );

endmodule

// File: source/refill_master.sv
// **************************************
// wishbone classic read master. fetches the missing word
// and writes it into the victim way.
// **************************************

`timescale 1ns/1ps

module refill_master import cache_pkg::*; #(
  parameter int N_WAYS = 2
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          miss,
  input  cache_addr_t                   addr_buf,
  input  logic [way_bits(N_WAYS)-1:0]   victim,
  // wishbone.
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output word_t                         wb_adr,
  input  logic [WORD_BITS-1:0]          wb_dat_r,
  input  logic                          wb_ack,
  // fill port to the ways.
  output logic                          fill_en,
  output logic [way_bits(N_WAYS)-1:0]   fill_way,
  output index_t                        fill_index,
  output tag_t                          fill_tag,
  output logic [WORD_BITS-1:0]          fill_data
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_REQ  = 2'd1;
  localparam logic [1:0] S_FILL = 2'd2;

  logic [1:0]                  state;
  cache_addr_t                 addr_q;
  logic [way_bits(N_WAYS)-1:0] way_q;
  logic [WORD_BITS-1:0]        data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= S_IDLE;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (miss) begin
          state  <= S_REQ;
          wb_cyc <= 1'b1;
          wb_stb <= 1'b1;
        end
        S_REQ: if (wb_ack) begin
          state  <= S_FILL;
          wb_cyc <= 1'b0;   // drop after the single-beat ack.
          wb_stb <= 1'b0;
        end
        default: state <= S_IDLE;  // fill lasts one cycle.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && miss) begin
      addr_q <= addr_buf;
      way_q  <= victim;
    end
    if (state == S_REQ && wb_ack) data_q <= wb_dat_r;
  end

  assign wb_adr     = addr_q.mem.word;
  assign fill_en    = (state == S_FILL);
  assign fill_way   = way_q;
  assign fill_index = addr_q.fields.index;
  assign fill_tag   = addr_q.fields.tag;
  assign fill_data  = data_q;

  a_stb_in_cyc: assert property (
    @(posedge clk) disable iff (rst)
    wb_stb |-> wb_cyc
  ) else $error("wb_stb without wb_cyc.");

endmodule

// File: tb/cache_tb.sv
// ****************************************
// directed testbench of the byte cache with a wishbone
// memory model and a reference model of the tags.
// ****************************************

`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

  localparam int TB_WAYS    = 2;
  localparam int WAIT_LIMIT = 64;

  logic        clk = 1'b0;
  logic        rst;
  logic        req_valid;
  cache_addr_t req_addr;
  logic        req_ready;
  logic        rsp_valid;
  logic [7:0]  rsp_data;
  logic        rsp_ready;
  logic        wb_cyc;
  logic        wb_stb;
  word_t       wb_adr;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  int          mismatches = 0;
  int          failures   = 0;
  int          wb_reads   = 0;
  int          exp_reads  = 0;
  word_t       exp_word   = '0;
  logic [31:0] lfsr       = 32'he321_b640;

  tag_t model_tag   [N_SETS][TB_WAYS];
  logic model_valid [N_SETS][TB_WAYS];
  int   model_rr    [N_SETS];

  cache_top #(.N_WAYS(TB_WAYS)) UUT (
    .clk(clk), .rst(rst),
    .req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_ready(rsp_ready),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  wb_mem_model u_mem (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    if (wb_cyc && wb_stb && wb_ack) begin
      wb_reads <= wb_reads + 1;  // one acked read.
      compare_word("wb_adr", wb_adr, exp_word);
    end
  end

  // ****************************************
  // reference rules
  // ****************************************

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // offset 0 is the top byte of the word.
  function automatic logic [7:0] expected_byte(input cache_addr_t a);
    logic [31:0] w;
    w = {8'hA5, a.mem.word[13:6], a.mem.word[5:0], 2'b01, ~a.mem.word[7:0]};
    return w[8*(3 - int'(a.mem.byte_sel)) +: 8];
  endfunction

  function automatic cache_addr_t make_addr(input tag_t t, input index_t i, input offset_t o);
    return cache_addr_t'({t, i, o});
  endfunction

  // returns the predicted hit and fills the round-robin victim on a miss.
  function automatic logic model_lookup(input cache_addr_t a);
    index_t s;
    logic   found;
    s     = a.fields.index;
    found = 1'b0;
    for (int w = 0; w < TB_WAYS; w++) begin
      if (model_valid[s][w] && model_tag[s][w] == a.fields.tag) found = 1'b1;
    end
    if (!found) begin
      model_tag[s][model_rr[s]]   = a.fields.tag;
      model_valid[s][model_rr[s]] = 1'b1;
      model_rr[s] = (model_rr[s] + 1) % TB_WAYS;
      exp_reads++;
    end
    return found;
  endfunction

  function automatic void model_clear();
    for (int s = 0; s < N_SETS; s++) begin
      model_rr[s] = 0;
      for (int w = 0; w < TB_WAYS; w++) model_valid[s][w] = 1'b0;
    end
  endfunction

  // ****************************************
  // checks and waits
  // ****************************************

  task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      mismatches++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got 0x%04h, expected 0x%04h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // waits sample on the falling edge half a cycle after the DUT moved.
  task automatic wait_req_ready(output bit ok);
    int n;
    n = 0;
    @(negedge clk);
    while (!req_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    ok = req_ready;
    if (!ok) report_failure("request was not accepted in time");
  endtask

  task automatic poll_rsp_valid(output int n, output bit ok);
    n = 0;
    @(negedge clk);
    while (!rsp_valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    ok = rsp_valid;
    if (!ok) report_failure("no response arrived in time");
  endtask

  task automatic apply_reset();
    rst       <= 1'b1;
    req_valid <= 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    model_clear();
  endtask

  // one request with a full handshake and a model-predicted hit or miss.
  task automatic read_byte(input cache_addr_t a);
    logic exp_hit;
    int   n;
    bit   ok;
    exp_hit  = model_lookup(a);
    exp_word = a.mem.word;
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr  <= a;
    rsp_ready <= 1'b1;
    wait_req_ready(ok);
    @(posedge clk);
    req_valid <= 1'b0;
    if (!ok) return;
    poll_rsp_valid(n, ok);
    if (!ok) return;
    if (exp_hit && n != 0) report_failure("predicted hit was answered late");
    if (!exp_hit && n == 0) report_failure("predicted miss was answered as a hit");
    compare_byte("rsp_data", rsp_data, expected_byte(a));
    compare_count("wb_reads", wb_reads, exp_reads);
    @(posedge clk);  // response taken here.
  endtask

  // ****************************************
  // tests
  // ****************************************

  task automatic read_one_word();
    int start;
    start = wb_reads;
    for (int o = 0; o < 4; o++) read_byte(make_addr(9'h024, 5'd13, offset_t'(o)));
    compare_count("reads for one word", wb_reads - start, 1);
  endtask

  task automatic evict_round_robin();
    int start;
    start = wb_reads;
    read_byte(make_addr(9'h011, 5'd5, 2'd0));
    read_byte(make_addr(9'h022, 5'd5, 2'd1));
    read_byte(make_addr(9'h011, 5'd5, 2'd2));
    read_byte(make_addr(9'h022, 5'd5, 2'd3));
    compare_count("reads for two resident tags", wb_reads - start, 2);
    read_byte(make_addr(9'h033, 5'd5, 2'd0));  // evicts tag 011 in way 0.
    read_byte(make_addr(9'h022, 5'd5, 2'd0));
    compare_count("reads after eviction", wb_reads - start, 3);
    read_byte(make_addr(9'h011, 5'd5, 2'd1));
    compare_count("reads for evicted tag", wb_reads - start, 4);
  endtask

  task automatic hold_under_backpressure();
    cache_addr_t a;
    logic [7:0]  first;
    int          n;
    bit          ok;
    a = make_addr(9'h033, 5'd5, 2'd2);
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr  <= a;
    rsp_ready <= 1'b1;
    wait_req_ready(ok);
    @(posedge clk);
    req_valid <= 1'b0;
    rsp_ready <= 1'b0;
    poll_rsp_valid(n, ok);
    first = rsp_data;
    repeat (6) begin
      @(negedge clk);
      if (!rsp_valid) report_failure("rsp_valid dropped while rsp_ready was low");
      if (req_ready) report_failure("req_ready was high while rsp_ready was low");
      compare_byte("held rsp_data", rsp_data, first);
    end
    compare_byte("rsp_data", rsp_data, expected_byte(a));
    @(posedge clk);
    rsp_ready <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    if (rsp_valid) report_failure("response was delivered more than once");
    compare_count("wb_reads", wb_reads, exp_reads);
  endtask

  // pipelined hits alternate between the two resident tags of set 5.
  task automatic pipeline_hits();
    cache_addr_t addrs [8];
    int          start;
    for (int i = 0; i < 8; i++) begin
      addrs[i] = make_addr(i[0] ? 9'h011 : 9'h033, 5'd5, offset_t'(i >> 1));
    end
    start = wb_reads;
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr  <= addrs[0];
    rsp_ready <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      if (!req_ready) report_failure("back-to-back hit was not accepted");
      if (i > 0) begin
        if (!rsp_valid) report_failure("hit response not one cycle after acceptance");
        compare_byte("pipelined rsp_data", rsp_data, expected_byte(addrs[i-1]));
      end
      @(posedge clk);
      if (i < 7) req_addr <= addrs[i+1];
      else       req_valid <= 1'b0;
    end
    @(negedge clk);
    if (!rsp_valid) report_failure("last hit response not one cycle after acceptance");
    compare_byte("pipelined rsp_data", rsp_data, expected_byte(addrs[7]));
    @(posedge clk);
    compare_count("reads during hits", wb_reads - start, 0);
  endtask

  task automatic invalidate_on_reset();
    cache_addr_t a;
    int          start;
    a = make_addr(9'h024, 5'd13, 2'd1);
    read_byte(a);
    apply_reset();
    start = wb_reads;
    read_byte(a);
    compare_count("reads after reset", wb_reads - start, 1);
  endtask

  // four tags over four sets give frequent evictions.
  task automatic random_stream();
    logic [15:0] r;
    for (int k = 0; k < 200; k++) begin
      r = take_bits(6);
      read_byte(make_addr({7'h10, r[5:4]}, {3'b100, r[3:2]}, r[1:0]));
    end
  endtask

  initial begin
    rst       = 1'b1;
    req_valid = 1'b0;
    req_addr  = '0;
    rsp_ready = 1'b0;
    apply_reset();
    read_one_word();
    evict_round_robin();
    hold_under_backpressure();
    pipeline_hits();
    invalidate_on_reset();
    random_stream();
    repeat (4) @(posedge clk);
    $display("summary: %0d mismatches, %0d other errors, %0d wishbone reads",
             mismatches, failures, wb_reads);
    if (mismatches == 0 && failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: tb/wb_mem_model.sv
// ****************************************
// wishbone classic slave memory for the cache testbench.
// word data follows a fixed rule, ack delay comes from an lfsr.
// ****************************************

`timescale 1ns/1ps

module wb_mem_model import cache_pkg::*; #(
  parameter logic [31:0] SEED = 32'he321_b640
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  word_t                wb_adr,
  output logic [WORD_BITS-1:0] wb_dat_r,
  output logic                 wb_ack
);

  logic [31:0] lfsr = SEED;
  logic        busy;
  logic [1:0]  wait_left;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // two lfsr bits give 0 to 3 extra wait states.
  function automatic logic [1:0] draw_waits();
    logic [1:0] v;
    v[1] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    v[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    return v;
  endfunction

  // high byte a5, then w[13:6], then w[5:0] with 01, then ~w[7:0].
  function automatic logic [31:0] word_at(input word_t w);
    return {8'hA5, w[13:6], w[5:0], 2'b01, ~w[7:0]};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= 1'b0;  // single cycle ack.
      if (wb_cyc && wb_stb && !wb_ack && !busy) begin
        busy      <= 1'b1;
        wait_left <= draw_waits();
      end else if (busy && wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else if (busy) begin
        busy     <= 1'b0;
        wb_ack   <= 1'b1;
        wb_dat_r <= word_at(wb_adr);
      end
    end
  end

endmodule
